//--- Makefile
TOP = adapter_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only -Wall -f vlog.f --top-module stream_adapter_top

clean:
	rm -rf obj_dir sim.log

//--- rtl/adapter_pkg.sv
// link word format for the host adapter; one value per output word, sample at most payload_bits
`default_nettype none

package adapter_pkg;

    // link word layout
    localparam int word_bits      = 32;
    localparam int soft_reset_bit = 31;  // input only, asks for a soft reset
    localparam int last_bit       = 30;  // end of vector, in and out
    localparam int payload_bits   = 30;  // bits 29..0 carry the value

    // sample width out of the host's converter
    localparam int default_value_bits = 18;

    // length of the channel vector the model produces
    localparam int default_channels = 10;

endpackage

`default_nettype wire

//--- rtl/sample_window.sv
// sliding sample window standing in for the model; holds one output vector, channels must be at least 2
`default_nettype none

module sample_window #(
    parameter int value_bits = adapter_pkg::default_value_bits,
    parameter int channels   = adapter_pkg::default_channels
) (
    input  logic                         clock,
    input  logic                         reset,

    input  logic signed [value_bits-1:0] sample,
    input  logic                         sample_valid,
    input  logic                         sample_last,
    output logic                         sample_stall,

    vector_stream_if.source              vec
);

    logic signed [value_bits-1:0] history      [channels];  // newest at index 0
    logic signed [value_bits-1:0] next_history [channels];
    logic                         accept;

    // only blocked while a finished vector waits on the serializer
    assign sample_stall = vec.valid && vec.stall;
    assign accept       = sample_valid && !sample_stall;

    // history after shifting in the current sample
    always_comb begin
        next_history[0] = sample;
        for (int k = 1; k < channels; k++) begin
            next_history[k] = history[k-1];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < channels; k++) begin
                history[k] <= '0;  // missing samples read as zero
            end
        end else if (accept) begin
            for (int k = 0; k < channels; k++) begin
                // a frame end starts the next frame from an empty window
                history[k] <= sample_last ? '0 : next_history[k];
            end
        end
    end

    // output vector register
    always_ff @(posedge clock) begin
        if (reset) begin
            vec.valid <= 1'b0;
            vec.last  <= 1'b0;
        end else if (accept) begin
            vec.valid <= 1'b1;
            vec.last  <= sample_last;
        end else if (!vec.stall) begin
            vec.valid <= 1'b0;  // taken by the serializer
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            vec.data <= next_history;  // the emitted vector includes the last sample
        end
    end

    // the serializer must always get a chance at a vector once offered
    vector_held: assert property (
        @(posedge clock) disable iff (reset)
        vec.valid && vec.stall |=> vec.valid && $stable(vec.last)
    );

endmodule

`default_nettype wire

//--- rtl/stream_adapter_top.sv
// host link adapter; value_bits must not exceed payload_bits, soft reset drops any vector still in flight
`default_nettype none

module stream_adapter_top #(
    parameter int value_bits = adapter_pkg::default_value_bits,
    parameter int channels   = adapter_pkg::default_channels
) (
    input  logic                              clock,
    input  logic                              reset,     // synchronous, active high

    input  logic [adapter_pkg::word_bits-1:0] in_data,
    input  logic                              in_valid,

    output logic [adapter_pkg::word_bits-1:0] out_data,
    output logic                              out_valid,

    input  logic                              downstream_stall,
    output logic                              upstream_stall
);

    import adapter_pkg::*;

    logic [word_bits-1:0]         in_word;
    logic                         in_word_valid;
    logic                         in_stage_stall;
    logic                         soft_reset;
    logic                         core_reset;
    logic                         is_sample;
    logic signed [value_bits-1:0] sample;
    logic                         sample_stall;
    logic [value_bits-1:0]        ser_value;
    logic                         ser_valid;
    logic                         ser_last;
    logic                         out_stage_stall;
    logic [word_bits-1:0]         ser_word;

    vector_stream_if #(.value_bits(value_bits), .channels(channels)) vec_stream ();

    // input side only sees the hard reset, so the request word itself gets consumed
    stream_register in_stage (
        .clock(clock), .reset(reset),
        .in_data(in_data), .in_valid(in_valid),
        .out_data(in_word), .out_valid(in_word_valid),
        .downstream_stall(in_stage_stall), .upstream_stall(upstream_stall)
    );

    // decode the registered word
    assign soft_reset = in_word_valid && in_word[soft_reset_bit];  // an idle bus never resets
    assign is_sample  = in_word_valid && !in_word[soft_reset_bit];
    assign core_reset = reset || soft_reset;
    assign sample     = signed'(in_word[value_bits-1:0]);  // bits above the sample are ignored

    // reset words never wait, so upstream_stall is low while one is held
    assign in_stage_stall = is_sample && sample_stall;

    sample_window #(.value_bits(value_bits), .channels(channels)) window (
        .clock(clock), .reset(core_reset),
        .sample(sample), .sample_valid(is_sample),
        .sample_last(in_word[last_bit]), .sample_stall(sample_stall),
        .vec(vec_stream.source)
    );

    vector_serializer #(.value_bits(value_bits), .channels(channels)) serializer (
        .clock(clock), .reset(core_reset),
        .vec(vec_stream.sink),
        .out_value(ser_value), .out_valid(ser_valid), .out_last(ser_last),
        .downstream_stall(out_stage_stall)
    );

    // output word format
    always_comb begin
        ser_word                   = '0;                       // bit 31 stays clear
        ser_word[payload_bits-1:0] = payload_bits'(ser_value);  // zero-extended
        ser_word[last_bit]         = ser_last;
    end

    stream_register out_stage (
        .clock(clock), .reset(core_reset),
        .in_data(ser_word), .in_valid(ser_valid),
        .out_data(out_data), .out_valid(out_valid),
        .downstream_stall(downstream_stall), .upstream_stall(out_stage_stall)
    );

endmodule

`default_nettype wire

//--- rtl/stream_register.sv
// one-word register stage for link words; no skid buffer, so upstream stalls whenever it is full and blocked
`default_nettype none

module stream_register (
    input  logic                           clock,
    input  logic                           reset,

    input  logic [adapter_pkg::word_bits-1:0] in_data,
    input  logic                           in_valid,

    output logic [adapter_pkg::word_bits-1:0] out_data,
    output logic                           out_valid,

    input  logic                           downstream_stall,
    output logic                           upstream_stall
);

    logic load;

    assign load = !out_valid || !downstream_stall;  // empty, or the held word leaves now
    assign upstream_stall = out_valid && downstream_stall;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves with a load
    always_ff @(posedge clock) begin
        if (load && in_valid) begin
            out_data <= in_data;
        end
    end

    // a blocked word must still be there, unchanged, on the next edge
    held_word_stable: assert property (
        @(posedge clock) disable iff (reset)
        out_valid && downstream_stall |=> out_valid && $stable(out_data)
    );

endmodule

`default_nettype wire

//--- rtl/vector_serializer.sv
// sends one buffered vector as channels words, channel 0 first; takes no new vector until the last word leaves
`default_nettype none

module vector_serializer #(
    parameter int value_bits = adapter_pkg::default_value_bits,
    parameter int channels   = adapter_pkg::default_channels
) (
    input  logic                  clock,
    input  logic                  reset,

    vector_stream_if.sink         vec,

    output logic [value_bits-1:0] out_value,
    output logic                  out_valid,
    output logic                  out_last,
    input  logic                  downstream_stall
);

    localparam int index_bits = (channels > 1) ? $clog2(channels) : 1;
    localparam logic [index_bits-1:0] last_index = index_bits'(channels - 1);

    logic signed [value_bits-1:0] data_buffer [channels];
    logic                         buffer_valid;
    logic                         buffer_last;
    logic [index_bits-1:0]        index;        // channel on the output now
    logic                         load;
    logic                         send;

    assign load = vec.valid && !buffer_valid;
    assign send = buffer_valid && !downstream_stall;

    assign vec.stall = buffer_valid;  // one vector at a time

    always_ff @(posedge clock) begin
        if (reset) begin
            buffer_valid <= 1'b0;
            buffer_last  <= 1'b0;
            index        <= '0;
        end else if (load) begin
            buffer_valid <= 1'b1;
            buffer_last  <= vec.last;
            index        <= '0;
        end else if (send) begin
            if (index == last_index) begin
                buffer_valid <= 1'b0;  // final channel went out
                index        <= '0;
            end else begin
                index <= index + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            data_buffer <= vec.data;
        end
    end

    // two's complement bits passed as they are, top level zero-extends
    assign out_value = unsigned'(data_buffer[index]);
    assign out_valid = buffer_valid;
    assign out_last  = buffer_last && (index == last_index);

    // index must wrap at the final channel, never step past it
    index_in_range: assert property (
        @(posedge clock) disable iff (reset)
        buffer_valid |-> int'(index) < channels
    );

endmodule

`default_nettype wire

//--- rtl/vector_stream_if.sv
// channel-vector stream between window and serializer; valid/stall handshake, no clock inside
`default_nettype none

interface vector_stream_if #(
    parameter int value_bits = adapter_pkg::default_value_bits,
    parameter int channels   = adapter_pkg::default_channels
);

    logic signed [value_bits-1:0] data [channels];  // channel 0 holds the newest sample
    logic                         valid;
    logic                         last;   // vector closes a host frame
    logic                         stall;  // receiver is busy, hold everything

    // producer side
    modport source (
        output data,
        output valid,
        output last,
        input  stall
    );

    // consumer side
    modport sink (
        input  data,
        input  valid,
        input  last,
        output stall
    );

endinterface

`default_nettype wire

//--- verification/adapter_tb.sv
// testbench for stream_adapter_top at default widths; samples flagged as dropped need a stall-free lead-up to their soft reset
`default_nettype none

module adapter_tb;

    import adapter_pkg::*;

    localparam int value_bits   = default_value_bits;
    localparam int channels     = default_channels;
    localparam int send_timeout = 500;   // cycles an input word may wait for acceptance
    localparam int word_timeout = 2000;  // cycles allowed for one test's output words
    localparam int quiet_cycles = 24;    // idle cycles that must stay free of stray words

    logic                 clock;
    logic                 reset;
    logic [word_bits-1:0] in_data;
    logic                 in_valid;
    logic [word_bits-1:0] out_data;
    logic                 out_valid;
    logic                 downstream_stall;
    logic                 upstream_stall;

    // stimulus table, one entry per input word
    string                step_name  [$];
    logic [word_bits-1:0] step_word  [$];
    bit                   step_lfsr  [$];  // random downstream stall while the step runs
    bit                   step_check [$];  // test ends here
    bit                   step_drop  [$];  // sample is lost to the soft reset that follows

    logic [word_bits-1:0]  expected_words [$];
    logic [word_bits-1:0]  received_words [$];
    logic [value_bits-1:0] ref_history [channels];  // newest sample at index 0

    logic [15:0] lfsr_state;
    bit          lfsr_mode;
    string       note;  // first failure seen in the running test
    int          tests;
    int          failures;

    stream_adapter_top uut (
        .clock(clock), .reset(reset),
        .in_data(in_data), .in_valid(in_valid),
        .out_data(out_data), .out_valid(out_valid),
        .downstream_stall(downstream_stall), .upstream_stall(upstream_stall)
    );

    always #20 clock = ~clock;

    // fibonacci form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    always @(posedge clock) begin
        if (lfsr_mode) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per stall bit
            downstream_stall <= lfsr_state[0];
        end else begin
            downstream_stall <= 1'b0;
        end
    end

    // a word moves on the next rising edge, its flags are settled at the falling one
    always @(negedge clock) begin
        if (!reset && out_valid && !downstream_stall) begin
            received_words.push_back(out_data);
        end
    end

    function automatic void add_step(input string name, input logic [word_bits-1:0] word,
                                     input bit lfsr, input bit check, input bit drop = 1'b0);
        step_name.push_back(name);
        step_word.push_back(word);
        step_lfsr.push_back(lfsr);
        step_check.push_back(check);
        step_drop.push_back(drop);
    endfunction

    function automatic void build_table();
        add_step("fill_short", 32'h0000_0011, 1'b0, 1'b0);
        add_step("fill_short", 32'h0000_0022, 1'b0, 1'b0);
        add_step("fill_short", 32'h0000_0033, 1'b0, 1'b1);  // upper channels still zero
        add_step("fill_full", 32'h0000_0044, 1'b0, 1'b0);
        add_step("fill_full", 32'h0000_0055, 1'b0, 1'b0);
        add_step("fill_full", 32'h0000_0066, 1'b0, 1'b0);
        add_step("fill_full", 32'h0000_0077, 1'b0, 1'b0);
        add_step("fill_full", 32'h0000_0088, 1'b0, 1'b0);
        add_step("fill_full", 32'h0000_0099, 1'b0, 1'b0);
        add_step("fill_full", 32'h0000_00aa, 1'b0, 1'b0);
        add_step("fill_full", 32'h0000_00bb, 1'b0, 1'b0);
        add_step("fill_full", 32'h0000_00cc, 1'b0, 1'b1);  // oldest samples fall out
        add_step("upper_bits", 32'h3ffc_0005, 1'b0, 1'b0);
        add_step("upper_bits", 32'h2aa8_1234, 1'b0, 1'b1);
        add_step("negative", 32'h0003_ffff, 1'b0, 1'b0);    // -1
        add_step("negative", 32'h0002_0000, 1'b0, 1'b1);    // most negative
        add_step("last_flag", 32'h4000_0123, 1'b0, 1'b1);
        add_step("after_last", 32'h0000_0456, 1'b0, 1'b1);
        add_step("soft_reset", 32'h0000_0777, 1'b0, 1'b0);        // fully sent before the reset
        add_step("soft_reset", 32'h0000_0778, 1'b0, 1'b0, 1'b1);  // still in the serializer
        add_step("soft_reset", 32'h0000_0779, 1'b0, 1'b0, 1'b1);  // window holds it, stalled
        add_step("soft_reset", 32'h8000_0000, 1'b0, 1'b1);
        add_step("after_soft_reset", 32'h0000_0888, 1'b0, 1'b1);
        add_step("stall_burst", 32'h0000_1001, 1'b1, 1'b0);
        add_step("stall_burst", 32'h0001_2002, 1'b1, 1'b0);
        add_step("stall_burst", 32'h4000_3003, 1'b1, 1'b0);  // frame end mid burst
        add_step("stall_burst", 32'h0002_4004, 1'b1, 1'b0);
        add_step("stall_burst", 32'h0003_5005, 1'b1, 1'b0);
        add_step("stall_burst", 32'h1000_6006, 1'b1, 1'b0);
        add_step("stall_burst", 32'h0000_7007, 1'b1, 1'b1);
        add_step("stall_soft_reset", 32'hc000_0000, 1'b1, 1'b1);
        add_step("stall_after_reset", 32'h0000_01ab, 1'b1, 1'b0);
        add_step("stall_after_reset", 32'h4000_01cd, 1'b1, 1'b1);
    endfunction

    function automatic void record_failure(input string message);
        if (note == "") begin
            note = message;
        end
    endfunction

    function automatic void clear_model();
        for (int k = 0; k < channels; k++) begin
            ref_history[k] = '0;
        end
    endfunction

    // channel k carries the sample taken k inputs ago, zero if none since the last clear
    function automatic void model_sample(input logic [word_bits-1:0] word);
        logic [value_bits-1:0] window [channels];
        logic [word_bits-1:0]  expected;
        bit                    is_last;
        is_last   = word[last_bit];
        window[0] = word[value_bits-1:0];
        for (int k = 1; k < channels; k++) begin
            window[k] = ref_history[k-1];
        end
        for (int k = 0; k < channels; k++) begin
            expected                 = '0;
            expected[value_bits-1:0] = window[k];
            expected[last_bit]       = is_last && (k == channels - 1);
            expected_words.push_back(expected);
        end
        for (int k = 0; k < channels; k++) begin
            ref_history[k] = is_last ? '0 : window[k];  // a frame end empties the window
        end
    endfunction

    task automatic send_word(input string name, input logic [word_bits-1:0] word);
        int cycles;
        @(posedge clock);
        in_data  <= word;
        in_valid <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
        end while (upstream_stall && cycles < send_timeout);
        in_valid <= 1'b0;
        if (upstream_stall) begin
            record_failure($sformatf("%s: input word %h was never accepted", name, word));
        end
    endtask

    task automatic finish_test(input string name);
        int cycles;
        int count;
        cycles = 0;
        while (received_words.size() < expected_words.size() && cycles < word_timeout) begin
            @(posedge clock);
            cycles++;
        end
        for (int i = 0; i < quiet_cycles; i++) begin
            @(posedge clock);
        end
        count = expected_words.size();
        if (received_words.size() < count) begin
            record_failure($sformatf("%s: timed out with %0d of %0d words received",
                                     name, received_words.size(), count));
        end else begin
            for (int i = 0; i < count; i++) begin
                if (received_words[i] !== expected_words[i]) begin
                    record_failure($sformatf("Fail %s: word %0d expected %h actual %h",
                                             name, i, expected_words[i], received_words[i]));
                end
            end
            if (received_words.size() > count) begin
                record_failure($sformatf("%s: %0d words came out where %0d were due",
                                         name, received_words.size(), count));
            end
        end
        tests++;
        if (note == "") begin
            $display("ok   %s", name);
        end else begin
            $display("%s", note);
            failures++;
        end
        note = "";
        expected_words.delete();
        received_words.delete();
    endtask

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        in_data          = '0;
        in_valid         = 1'b0;
        downstream_stall = 1'b0;
        lfsr_state       = 16'd50;  // seed
        lfsr_mode        = 1'b0;
        note             = "";
        tests            = 0;
        failures         = 0;
        clear_model();
        build_table();
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        // nothing may move without input
        for (int i = 0; i < quiet_cycles; i++) begin
            @(posedge clock);
            if (out_valid || upstream_stall) begin
                record_failure("reset_idle: out_valid or upstream_stall high with no input");
            end
        end
        finish_test("reset_idle");

        for (int i = 0; i < step_word.size(); i++) begin
            lfsr_mode <= step_lfsr[i];
            send_word(step_name[i], step_word[i]);
            if (step_word[i][soft_reset_bit]) begin
                clear_model();
                @(posedge clock);  // request word sits in the input register this cycle
                if (upstream_stall) begin
                    record_failure($sformatf("%s: upstream_stall high while the reset word was held",
                                             step_name[i]));
                end
            end else if (!step_drop[i]) begin
                model_sample(step_word[i]);
            end
            if (step_check[i]) begin
                finish_test(step_name[i]);
            end
        end

        $display("%0d tests, %0d failed", tests, failures);
        if (failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/adapter_pkg.sv
rtl/vector_stream_if.sv
rtl/stream_register.sv
rtl/sample_window.sv
rtl/vector_serializer.sv
rtl/stream_adapter_top.sv
verification/adapter_tb.sv
